// ==== src/gmii_pkg.sv ====
package gmii_pkg;

	// ------------------------------------------------------------------
	// Data widths
	// ------------------------------------------------------------------

	// One GMII byte lane
	typedef logic [7:0] byte_t;
	// Pixel word, luma in the high byte
	typedef logic [15:0] pixel_t;
	typedef logic [15:0] sample_t;
	// Line counter inside a video frame
	typedef logic [11:0] line_num_t;
	typedef logic [31:0] crc_t;

	// Transmitter FSM, one state per frame field
	typedef enum logic [3:0] {
		IDLE, PREAMBLE, SFD,
		ETH_HDR, IP_HDR, UDP_HDR,
		PKT_TYPE, LINE_NUM, VIDEO_DATA,
		AUX_COUNT, AUX_DATA,
		FCS, GAP
	} tx_state_t;

	// Packet type byte after the UDP header
	localparam byte_t PKT_VIDEO = 8'd0;
	localparam byte_t PKT_AUDIO = 8'd1;

	// ------------------------------------------------------------------
	// Header fields
	// ------------------------------------------------------------------

	// Last byte of each address is adjusted by station_id
	localparam logic [47:0] SRC_MAC = 48'h00_23_45_67_89_01;
	localparam logic [47:0] DST_MAC = 48'h00_23_45_67_89_02;
	localparam logic [15:0] ETH_TYPE_IP = 16'h0800;

	// Version 4, 20 byte header, no TOS
	localparam logic [15:0] IP_VER_TOS = 16'h4500;
	localparam logic [15:0] IP_IDENT = 16'h0000;
	// Don't fragment
	localparam logic [15:0] IP_FLAGS = 16'h4000;
	// TTL 64, protocol UDP
	localparam logic [15:0] IP_TTL_PROTO = 16'h4011;
	localparam logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] DST_IP = {8'd192, 8'd168, 8'd0, 8'd2};

	localparam logic [15:0] UDP_SRC_PORT = 16'h3038;
	localparam logic [15:0] UDP_DST_PORT = 16'h3039;

	// Bytes of 0x55 ahead of the SFD
	localparam int PREAMBLE_LEN = 7;
	// Idle cycles between frames
	localparam int GAP_CYCLES = 12;

endpackage

// ==== src/crc32_gen.sv ====
`timescale 1ns/1ps

module crc32_gen (
	input  logic            fifo_clk,
	input  logic            sys_rst,
	input  logic            crc_init,
	input  logic            crc_en,
	input  gmii_pkg::byte_t crc_byte,
	output gmii_pkg::crc_t  crc_value
);

	gmii_pkg::crc_t crc_reg;

	// One byte through the reflected polynomial, LSB first
	function automatic gmii_pkg::crc_t crc_step(input gmii_pkg::crc_t crc,
		input gmii_pkg::byte_t data);
		gmii_pkg::crc_t c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ data[i]) begin
				// 0x04C11DB7 bit reversed
				c = (c >> 1) ^ 32'hedb88320;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge fifo_clk) begin
		if (sys_rst || crc_init) begin
			crc_reg <= '1;
		end else if (crc_en) begin
			crc_reg <= crc_step(crc_reg, crc_byte);
		end
	end

	// Complemented register, low byte moved to 31:24 so it goes out first
	assign crc_value = ~{crc_reg[7:0], crc_reg[15:8], crc_reg[23:16], crc_reg[31:24]};

endmodule

// ==== src/video_line_buffer.sv ====
`timescale 1ns/1ps

module video_line_buffer #(
	parameter int VIDEO_PIXELS    = 640,
	parameter int FIFO_DEPTH_LOG2 = 10
) (
	input  logic             fifo_clk,
	input  logic             sys_rst,
	input  logic             pix_wr,
	input  gmii_pkg::pixel_t pix_data,
	input  logic             vid_rd,
	output gmii_pkg::pixel_t vid_data,
	output logic             line_ready,
	output logic             vid_overflow
);

	// Occupancy is one bit wider than the pointers
	typedef logic [FIFO_DEPTH_LOG2:0]   level_t;
	typedef logic [FIFO_DEPTH_LOG2-1:0] addr_t;

	localparam level_t DEPTH      = level_t'(2 ** FIFO_DEPTH_LOG2);
	localparam level_t LINE_WORDS = level_t'(VIDEO_PIXELS);

	gmii_pkg::pixel_t mem [2 ** FIFO_DEPTH_LOG2];
	addr_t            wr_ptr;
	addr_t            rd_ptr;
	level_t           level;
	logic             do_wr;
	logic             do_rd;

	// Writes to a full buffer are lost
	assign do_wr = pix_wr && (level != DEPTH);
	assign do_rd = vid_rd && (level != '0);

	always_ff @(posedge fifo_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= pix_data;
		end
	end

	// ------------------------------------------------------------------
	// Pointers, level and overflow
	// ------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			level        <= '0;
			vid_overflow <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			level <= level + level_t'(do_wr) - level_t'(do_rd);
			// Sticky until reset
			if (pix_wr && level == DEPTH) begin
				vid_overflow <= 1'b1;
			end
		end
	end

	// Show-ahead head word
	assign vid_data   = mem[rd_ptr];
	assign line_ready = (level >= LINE_WORDS);

	// Transmitter only reads a buffer that was granted with a full line
	assert property (@(posedge fifo_clk) disable iff (sys_rst) vid_rd |-> level != '0)
	else $error("video buffer popped while empty");

endmodule

// ==== src/aux_sample_buffer.sv ====
`timescale 1ns/1ps

module aux_sample_buffer #(
	parameter int AUX_SAMPLES     = 32,
	parameter int FIFO_DEPTH_LOG2 = 10
) (
	input  logic              fifo_clk,
	input  logic              sys_rst,
	input  logic              aud_wr,
	input  gmii_pkg::sample_t aud_data,
	input  logic              aud_rd,
	output gmii_pkg::sample_t aud_data_out,
	output logic              block_ready,
	output logic              aud_overflow
);

	typedef logic [FIFO_DEPTH_LOG2:0]   level_t;
	typedef logic [FIFO_DEPTH_LOG2-1:0] addr_t;

	localparam level_t DEPTH       = level_t'(2 ** FIFO_DEPTH_LOG2);
	localparam level_t BLOCK_WORDS = level_t'(AUX_SAMPLES);

	gmii_pkg::sample_t mem [2 ** FIFO_DEPTH_LOG2];
	addr_t             wr_ptr;
	addr_t             rd_ptr;
	level_t            level;
	logic              do_wr;
	logic              do_rd;

	assign do_wr = aud_wr && (level != DEPTH);
	assign do_rd = aud_rd && (level != '0);

	always_ff @(posedge fifo_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= aud_data;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			level        <= '0;
			aud_overflow <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			level <= level + level_t'(do_wr) - level_t'(do_rd);
			// Dropped sample, held until reset
			if (aud_wr && level == DEPTH) begin
				aud_overflow <= 1'b1;
			end
		end
	end

	assign aud_data_out = mem[rd_ptr];
	// One full audio block waiting
	assign block_ready  = (level >= BLOCK_WORDS);

	assert property (@(posedge fifo_clk) disable iff (sys_rst) aud_rd |-> level != '0)
	else $error("audio buffer popped while empty");

endmodule

// ==== src/frame_arbiter.sv ====
`timescale 1ns/1ps

module frame_arbiter (
	input  logic fifo_clk,
	input  logic sys_rst,
	input  logic line_ready,
	input  logic block_ready,
	input  logic tx_busy,
	output logic grant_video,
	output logic grant_audio
);

	// Set when video got the most recent grant
	logic last_video;
	logic pick_video;
	logic pick_audio;

	// Round robin when both sources are waiting
	assign pick_video = line_ready && (!block_ready || !last_video);
	assign pick_audio = block_ready && !pick_video;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			grant_video <= 1'b0;
			grant_audio <= 1'b0;
			last_video  <= 1'b0;
		end else begin
			grant_video <= 1'b0;
			grant_audio <= 1'b0;
			// tx_busy rises one cycle after a grant, so hold off that cycle too
			if (!tx_busy && !grant_video && !grant_audio) begin
				grant_video <= pick_video;
				grant_audio <= pick_audio;
				if (pick_video) begin
					last_video <= 1'b1;
				end else if (pick_audio) begin
					last_video <= 1'b0;
				end
			end
		end
	end

	assert property (@(posedge fifo_clk) disable iff (sys_rst)
		!(grant_video && grant_audio))
	else $error("video and audio granted together");

	// Every grant starts a frame in the transmitter
	assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(grant_video || grant_audio) |=> tx_busy)
	else $error("grant not taken by transmitter");

endmodule

// ==== src/gmii_frame_tx.sv ====
`timescale 1ns/1ps

module gmii_frame_tx #(
	parameter int VIDEO_PIXELS = 640,
	parameter int AUX_SAMPLES  = 32,
	parameter int VIDEO_LINES  = 720
) (
	input  logic              fifo_clk,
	input  logic              sys_rst,
	input  logic              station_id,
	input  logic              grant_video,
	input  logic              grant_audio,
	input  gmii_pkg::pixel_t  vid_data,
	input  gmii_pkg::sample_t aud_data_out,
	output logic              vid_rd,
	output logic              aud_rd,
	output logic              tx_busy,
	output logic              tx_en,
	output gmii_pkg::byte_t   txd
);

	// ------------------------------------------------------------------
	// Lengths and field ends
	// ------------------------------------------------------------------
	// UDP header, type, line number, two bytes per pixel
	localparam logic [15:0] UDP_LEN_VID = 16'(8 + 1 + 2 + 2 * VIDEO_PIXELS);
	// UDP header, type, sample count, two bytes per sample
	localparam logic [15:0] UDP_LEN_AUD = 16'(8 + 1 + 1 + 2 * AUX_SAMPLES);
	localparam logic [15:0] IP_LEN_VID  = UDP_LEN_VID + 16'd20;
	localparam logic [15:0] IP_LEN_AUD  = UDP_LEN_AUD + 16'd20;
	localparam logic [15:0] VID_LAST    = 16'(2 * VIDEO_PIXELS - 1);
	localparam logic [15:0] AUD_LAST    = 16'(2 * AUX_SAMPLES - 1);
	localparam logic [15:0] PRE_LAST    = 16'(gmii_pkg::PREAMBLE_LEN - 1);
	// First gap cycle still shows the last FCS byte
	localparam logic [15:0] GAP_LAST    = 16'(gmii_pkg::GAP_CYCLES);
	localparam gmii_pkg::line_num_t LINE_WRAP = gmii_pkg::line_num_t'(VIDEO_LINES - 1);

	gmii_pkg::tx_state_t state;
	gmii_pkg::tx_state_t state_next;
	logic [15:0]         byte_cnt;
	logic                field_last;
	logic                load_en;
	gmii_pkg::byte_t     next_byte;
	logic                is_video;
	gmii_pkg::line_num_t line_num;
	logic [19:0]         ip_sum;
	logic [19:0]         hdr_sum;
	logic [15:0]         ip_len;
	logic [15:0]         udp_len;
	gmii_pkg::byte_t     src_mac_last;
	gmii_pkg::byte_t     dst_mac_last;
	gmii_pkg::byte_t     src_ip_last;
	gmii_pkg::byte_t     dst_ip_last;
	logic [111:0]        eth_hdr;
	logic [159:0]        ip_hdr;
	logic [63:0]         udp_hdr;
	logic                crc_init;
	logic                crc_en;
	gmii_pkg::crc_t      crc_value;

	// Station adjust on the low address bytes
	assign src_mac_last = gmii_pkg::SRC_MAC[7:0] + {7'd0, station_id};
	assign dst_mac_last = gmii_pkg::DST_MAC[7:0] - {7'd0, station_id};
	assign src_ip_last  = gmii_pkg::SRC_IP[7:0] + {7'd0, station_id};
	assign dst_ip_last  = gmii_pkg::DST_IP[7:0] - {7'd0, station_id};

	assign ip_len  = is_video ? IP_LEN_VID : IP_LEN_AUD;
	assign udp_len = is_video ? UDP_LEN_VID : UDP_LEN_AUD;

	// Fixed IP header words, total length is added in the preamble
	assign hdr_sum = 20'(gmii_pkg::IP_VER_TOS) + 20'(gmii_pkg::IP_IDENT)
		+ 20'(gmii_pkg::IP_FLAGS) + 20'(gmii_pkg::IP_TTL_PROTO)
		+ 20'(gmii_pkg::SRC_IP[31:16]) + 20'({gmii_pkg::SRC_IP[15:8], src_ip_last})
		+ 20'(gmii_pkg::DST_IP[31:16]) + 20'({gmii_pkg::DST_IP[15:8], dst_ip_last});

	// Headers as flat vectors, first byte on the wire at the top
	assign eth_hdr = {gmii_pkg::DST_MAC[47:8], dst_mac_last,
		gmii_pkg::SRC_MAC[47:8], src_mac_last, gmii_pkg::ETH_TYPE_IP};
	assign ip_hdr = {gmii_pkg::IP_VER_TOS, ip_len, gmii_pkg::IP_IDENT,
		gmii_pkg::IP_FLAGS, gmii_pkg::IP_TTL_PROTO, ~ip_sum[15:0],
		gmii_pkg::SRC_IP[31:8], src_ip_last, gmii_pkg::DST_IP[31:8], dst_ip_last};
	// UDP checksum left at zero
	assign udp_hdr = {gmii_pkg::UDP_SRC_PORT, gmii_pkg::UDP_DST_PORT, udp_len, 16'h0000};

	// ------------------------------------------------------------------
	// Byte select for the next txd value
	// ------------------------------------------------------------------
	always_comb begin
		load_en    = 1'b1;
		field_last = 1'b0;
		state_next = state;
		next_byte  = 8'h55;
		crc_init   = 1'b0;
		crc_en     = 1'b0;
		vid_rd     = 1'b0;
		aud_rd     = 1'b0;
		case (state)
			gmii_pkg::IDLE: begin
				// First preamble byte goes out with the grant
				load_en    = grant_video || grant_audio;
				field_last = load_en;
				state_next = gmii_pkg::PREAMBLE;
			end
			gmii_pkg::PREAMBLE: begin
				field_last = (byte_cnt == PRE_LAST);
				state_next = gmii_pkg::SFD;
			end
			gmii_pkg::SFD: begin
				next_byte  = 8'hd5;
				crc_init   = 1'b1;
				field_last = 1'b1;
				state_next = gmii_pkg::ETH_HDR;
			end
			gmii_pkg::ETH_HDR: begin
				next_byte  = eth_hdr[8 * (13 - byte_cnt) +: 8];
				crc_en     = 1'b1;
				field_last = (byte_cnt == 16'd13);
				state_next = gmii_pkg::IP_HDR;
			end
			gmii_pkg::IP_HDR: begin
				next_byte  = ip_hdr[8 * (19 - byte_cnt) +: 8];
				crc_en     = 1'b1;
				field_last = (byte_cnt == 16'd19);
				state_next = gmii_pkg::UDP_HDR;
			end
			gmii_pkg::UDP_HDR: begin
				next_byte  = udp_hdr[8 * (7 - byte_cnt) +: 8];
				crc_en     = 1'b1;
				field_last = (byte_cnt == 16'd7);
				state_next = gmii_pkg::PKT_TYPE;
			end
			gmii_pkg::PKT_TYPE: begin
				next_byte  = is_video ? gmii_pkg::PKT_VIDEO : gmii_pkg::PKT_AUDIO;
				crc_en     = 1'b1;
				field_last = 1'b1;
				state_next = is_video ? gmii_pkg::LINE_NUM : gmii_pkg::AUX_COUNT;
			end
			gmii_pkg::LINE_NUM: begin
				// 16 bit field, high byte first
				next_byte  = byte_cnt[0] ? line_num[7:0] : {4'd0, line_num[11:8]};
				crc_en     = 1'b1;
				field_last = (byte_cnt == 16'd1);
				state_next = gmii_pkg::VIDEO_DATA;
			end
			gmii_pkg::VIDEO_DATA: begin
				next_byte  = byte_cnt[0] ? vid_data[7:0] : vid_data[15:8];
				// Pop with the low byte, next head valid for the following byte
				vid_rd     = byte_cnt[0];
				crc_en     = 1'b1;
				field_last = (byte_cnt == VID_LAST);
				state_next = gmii_pkg::FCS;
			end
			gmii_pkg::AUX_COUNT: begin
				next_byte  = gmii_pkg::byte_t'(AUX_SAMPLES);
				crc_en     = 1'b1;
				field_last = 1'b1;
				state_next = gmii_pkg::AUX_DATA;
			end
			gmii_pkg::AUX_DATA: begin
				next_byte  = byte_cnt[0] ? aud_data_out[7:0] : aud_data_out[15:8];
				aud_rd     = byte_cnt[0];
				crc_en     = 1'b1;
				field_last = (byte_cnt == AUD_LAST);
				state_next = gmii_pkg::FCS;
			end
			gmii_pkg::FCS: begin
				// CRC register holds, crc_en is low here
				next_byte  = crc_value[8 * (3 - byte_cnt[1:0]) +: 8];
				field_last = (byte_cnt == 16'd3);
				state_next = gmii_pkg::GAP;
			end
			default: begin
				// Inter-frame gap
				load_en    = 1'b0;
				next_byte  = 8'h00;
				field_last = (byte_cnt == GAP_LAST);
				state_next = gmii_pkg::IDLE;
			end
		endcase
	end

	crc32_gen u_crc (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.crc_init  (crc_init),
		.crc_en    (crc_en),
		.crc_byte  (next_byte),
		.crc_value (crc_value)
	);

	// ------------------------------------------------------------------
	// FSM, output registers and line counter
	// ------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state    <= gmii_pkg::IDLE;
			byte_cnt <= '0;
			is_video <= 1'b0;
			line_num <= '0;
			tx_en    <= 1'b0;
			txd      <= '0;
		end else begin
			tx_en <= load_en;
			txd   <= load_en ? next_byte : 8'h00;
			// Preamble byte 0 is sent from IDLE
			if (state == gmii_pkg::IDLE) begin
				byte_cnt <= 16'd1;
			end else if (field_last) begin
				byte_cnt <= '0;
			end else begin
				byte_cnt <= byte_cnt + 16'd1;
			end
			if (field_last) begin
				state <= state_next;
			end
			if (state == gmii_pkg::IDLE && load_en) begin
				is_video <= grant_video;
			end
			// Next line number once the video frame is out
			if (state == gmii_pkg::FCS && field_last && is_video) begin
				line_num <= (line_num == LINE_WRAP) ? '0 : line_num + 1'b1;
			end
		end
	end

	// IP checksum built and folded while the preamble goes out
	always_ff @(posedge fifo_clk) begin
		if (state == gmii_pkg::IDLE) begin
			ip_sum <= hdr_sum;
		end else if (state == gmii_pkg::PREAMBLE) begin
			if (byte_cnt == 16'd1) begin
				ip_sum <= ip_sum + 20'(ip_len);
			end else begin
				// End-around carry
				ip_sum <= {4'd0, ip_sum[15:0]} + 20'(ip_sum[19:16]);
			end
		end
	end

	assign tx_busy = (state != gmii_pkg::IDLE);

	// Output stays quiet for the whole gap after the last FCS byte
	assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(state == gmii_pkg::GAP && $past(state) == gmii_pkg::GAP) |-> !tx_en)
	else $error("tx_en high during inter-frame gap");

endmodule

// ==== src/gmii_udp_top.sv ====
`timescale 1ns/1ps

module gmii_udp_top #(
	parameter int VIDEO_PIXELS    = 640,
	parameter int AUX_SAMPLES     = 32,
	parameter int VIDEO_LINES     = 720,
	parameter int FIFO_DEPTH_LOG2 = 10
) (
	input  logic              fifo_clk,
	input  logic              sys_rst,
	input  logic              station_id,
	input  logic              pix_wr,
	input  gmii_pkg::pixel_t  pix_data,
	input  logic              aud_wr,
	input  gmii_pkg::sample_t aud_data,
	output logic              tx_en,
	output gmii_pkg::byte_t   txd,
	output logic              vid_overflow,
	output logic              aud_overflow
);

	gmii_pkg::pixel_t  vid_data;
	gmii_pkg::sample_t aud_data_out;
	logic              vid_rd;
	logic              aud_rd;
	logic              line_ready;
	logic              block_ready;
	logic              tx_busy;
	logic              grant_video;
	logic              grant_audio;

	// ------------------------------------------------------------------
	// Source buffers
	// ------------------------------------------------------------------
	video_line_buffer #(
		.VIDEO_PIXELS    (VIDEO_PIXELS),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) u_video_buf (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.pix_wr       (pix_wr),
		.pix_data     (pix_data),
		.vid_rd       (vid_rd),
		.vid_data     (vid_data),
		.line_ready   (line_ready),
		.vid_overflow (vid_overflow)
	);

	aux_sample_buffer #(
		.AUX_SAMPLES     (AUX_SAMPLES),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) u_aux_buf (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.aud_wr       (aud_wr),
		.aud_data     (aud_data),
		.aud_rd       (aud_rd),
		.aud_data_out (aud_data_out),
		.block_ready  (block_ready),
		.aud_overflow (aud_overflow)
	);

	// ------------------------------------------------------------------
	// Shared transmit path
	// ------------------------------------------------------------------
	frame_arbiter u_arbiter (
		.fifo_clk    (fifo_clk),
		.sys_rst     (sys_rst),
		.line_ready  (line_ready),
		.block_ready (block_ready),
		.tx_busy     (tx_busy),
		.grant_video (grant_video),
		.grant_audio (grant_audio)
	);

	gmii_frame_tx #(
		.VIDEO_PIXELS (VIDEO_PIXELS),
		.AUX_SAMPLES  (AUX_SAMPLES),
		.VIDEO_LINES  (VIDEO_LINES)
	) u_frame_tx (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.station_id   (station_id),
		.grant_video  (grant_video),
		.grant_audio  (grant_audio),
		.vid_data     (vid_data),
		.aud_data_out (aud_data_out),
		.vid_rd       (vid_rd),
		.aud_rd       (aud_rd),
		.tx_busy      (tx_busy),
		.tx_en        (tx_en),
		.txd          (txd)
	);

endmodule

// ==== testbench/tb_frame_model.svh ====
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// ----------------------------------------------------------------------
// Expected-frame model, stimulus queues and random source
// ----------------------------------------------------------------------

// Words in write order, consumed as frames come out
gmii_pkg::pixel_t  pix_queue [$];
gmii_pkg::sample_t aud_queue [$];
// Model frame, preamble through FCS
gmii_pkg::byte_t   exp_frame [$];
logic [31:0]       lcg_state;

// LCG step, upper half mixes better
function automatic logic [15:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state[31:16];
endfunction

// Field onto the model frame, MSB first
function automatic void append_field(input logic [47:0] value, input int nbytes);
	for (int i = nbytes - 1; i >= 0; i--) begin
		exp_frame.push_back(value[8 * i +: 8]);
	end
endfunction

// Normal-form CRC-32 step, data bits taken LSB first as on the wire
function automatic gmii_pkg::crc_t crc_feed_byte(input gmii_pkg::crc_t crc,
	input gmii_pkg::byte_t data);
	gmii_pkg::crc_t c;
	c = crc;
	for (int i = 0; i < 8; i++) begin
		if (c[31] ^ data[i]) begin
			c = (c << 1) ^ 32'h04c11db7;
		end else begin
			c = c << 1;
		end
	end
	return c;
endfunction

// FCS over model bytes from index first on, wire order at 31:24 down
function automatic gmii_pkg::crc_t frame_fcs(input int first);
	gmii_pkg::crc_t c;
	gmii_pkg::crc_t r;
	c = '1;
	for (int i = first; i < exp_frame.size(); i++) begin
		c = crc_feed_byte(c, exp_frame[i]);
	end
	c = ~c;
	for (int i = 0; i < 32; i++) begin
		r[i] = c[31 - i];
	end
	// Reflected result, low byte leads
	return {r[7:0], r[15:8], r[23:16], r[31:24]};
endfunction

// Ones-complement sum of the ten header words, checksum field as zero
function automatic logic [15:0] ip_checksum(input logic [15:0] total_len,
	input logic [31:0] src_ip, input logic [31:0] dst_ip);
	logic [31:0] sum;
	sum = 32'(gmii_pkg::IP_VER_TOS) + 32'(total_len) + 32'(gmii_pkg::IP_IDENT)
		+ 32'(gmii_pkg::IP_FLAGS) + 32'(gmii_pkg::IP_TTL_PROTO)
		+ 32'(src_ip[31:16]) + 32'(src_ip[15:0])
		+ 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);
	while (sum[31:16] != 16'd0) begin
		sum = 32'(sum[15:0]) + 32'(sum[31:16]);
	end
	return ~sum[15:0];
endfunction

// Whole frame for one grant, pops the words it carries
function automatic void build_expected(input bit video, input logic sid, input int line);
	logic [47:0] dst_mac;
	logic [47:0] src_mac;
	logic [31:0] dst_ip;
	logic [31:0] src_ip;
	logic [15:0] udp_len;
	logic [15:0] ip_len;
	// Station id moves only the last address byte
	dst_mac = {gmii_pkg::DST_MAC[47:8], gmii_pkg::DST_MAC[7:0] - 8'(sid)};
	src_mac = {gmii_pkg::SRC_MAC[47:8], gmii_pkg::SRC_MAC[7:0] + 8'(sid)};
	dst_ip  = {gmii_pkg::DST_IP[31:8], gmii_pkg::DST_IP[7:0] - 8'(sid)};
	src_ip  = {gmii_pkg::SRC_IP[31:8], gmii_pkg::SRC_IP[7:0] + 8'(sid)};
	udp_len = video ? 16'(8 + 1 + 2 + 2 * VIDEO_PIXELS) : 16'(8 + 1 + 1 + 2 * AUX_SAMPLES);
	ip_len  = udp_len + 16'd20;
	exp_frame = {};
	repeat (gmii_pkg::PREAMBLE_LEN) begin
		exp_frame.push_back(8'h55);
	end
	exp_frame.push_back(8'hd5);
	append_field(dst_mac, 6);
	append_field(src_mac, 6);
	append_field(48'(gmii_pkg::ETH_TYPE_IP), 2);
	append_field(48'(gmii_pkg::IP_VER_TOS), 2);
	append_field(48'(ip_len), 2);
	append_field(48'(gmii_pkg::IP_IDENT), 2);
	append_field(48'(gmii_pkg::IP_FLAGS), 2);
	append_field(48'(gmii_pkg::IP_TTL_PROTO), 2);
	append_field(48'(ip_checksum(ip_len, src_ip, dst_ip)), 2);
	append_field(48'(src_ip), 4);
	append_field(48'(dst_ip), 4);
	append_field(48'(gmii_pkg::UDP_SRC_PORT), 2);
	append_field(48'(gmii_pkg::UDP_DST_PORT), 2);
	append_field(48'(udp_len), 2);
	append_field(48'd0, 2);
	if (video) begin
		exp_frame.push_back(gmii_pkg::PKT_VIDEO);
		append_field(48'(line), 2);
		for (int i = 0; i < VIDEO_PIXELS; i++) begin
			append_field(48'(pix_queue.pop_front()), 2);
		end
	end else begin
		exp_frame.push_back(gmii_pkg::PKT_AUDIO);
		exp_frame.push_back(8'(AUX_SAMPLES));
		for (int i = 0; i < AUX_SAMPLES; i++) begin
			append_field(48'(aud_queue.pop_front()), 2);
		end
	end
	// CRC covers destination MAC through payload
	append_field(48'(frame_fcs(8)), 4);
endfunction

`endif

// ==== testbench/tb_gmii_udp.sv ====
`timescale 1ns/1ps

module tb_gmii_udp;

	localparam int VIDEO_PIXELS    = 8;
	localparam int AUX_SAMPLES     = 4;
	localparam int VIDEO_LINES     = 3;
	localparam int FIFO_DEPTH_LOG2 = 4;
	localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_LOG2;
	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 4;
	// Preamble and SFD, headers, type byte, payload, FCS
	localparam int VIDEO_LEN = 8 + 42 + 1 + 2 + 2 * VIDEO_PIXELS + 4;
	localparam int AUDIO_LEN = 8 + 42 + 1 + 1 + 2 * AUX_SAMPLES + 4;
	localparam int LONGEST   = (VIDEO_LEN > AUDIO_LEN) ? VIDEO_LEN : AUDIO_LEN;
	localparam int WATCHDOG_NS = 20 * (LONGEST + gmii_pkg::GAP_CYCLES) * CLK_PERIOD * 2;
	// Index of the packet type byte
	localparam int TYPE_POS = 50;

	logic              fifo_clk;
	logic              sys_rst;
	logic              station_id;
	logic              pix_wr;
	gmii_pkg::pixel_t  pix_data;
	logic              aud_wr;
	gmii_pkg::sample_t aud_data;
	logic              tx_en;
	gmii_pkg::byte_t   txd;
	logic              vid_overflow;
	logic              aud_overflow;

	string             test_name;
	gmii_pkg::byte_t   cap_frame [$];
	// Expected frame kinds in send order, 1 for video
	bit                exp_video [$];
	logic              frame_sid;
	int                frames_done    = 0;
	int                frames_planned = 0;
	int                exp_line       = 0;
	int                idle_cycles    = gmii_pkg::GAP_CYCLES;

	`include "tb_frame_model.svh"

	gmii_udp_top #(
		.VIDEO_PIXELS    (VIDEO_PIXELS),
		.AUX_SAMPLES     (AUX_SAMPLES),
		.VIDEO_LINES     (VIDEO_LINES),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) u_dut (
		.fifo_clk     (fifo_clk),
		.sys_rst      (sys_rst),
		.station_id   (station_id),
		.pix_wr       (pix_wr),
		.pix_data     (pix_data),
		.aud_wr       (aud_wr),
		.aud_data     (aud_data),
		.tx_en        (tx_en),
		.txd          (txd),
		.vid_overflow (vid_overflow),
		.aud_overflow (aud_overflow)
	);

	initial begin
		fifo_clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) fifo_clk = ~fifo_clk;
		end
	end

	// ------------------------------------------------------------------
	// Failure reporting
	// ------------------------------------------------------------------
	task automatic flag_mismatch(input string what, input longint expected, input longint actual);
		$display("ERR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic stop_with_message(input string msg);
		$display("%s: %s", test_name, msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	// Outputs quiet in the cycle after any reset cycle
	assert property (@(posedge fifo_clk) $past(sys_rst) |-> !tx_en && !vid_overflow && !aud_overflow)
	else stop_with_message("outputs not cleared by reset");

	// Overflow flags are sticky
	assert property (@(posedge fifo_clk) $fell(vid_overflow) |-> $past(sys_rst))
	else stop_with_message("vid_overflow cleared without reset");
	assert property (@(posedge fifo_clk) $fell(aud_overflow) |-> $past(sys_rst))
	else stop_with_message("aud_overflow cleared without reset");

	// ------------------------------------------------------------------
	// Frame capture, mid-cycle where outputs are settled
	// ------------------------------------------------------------------
	task automatic check_frame();
		bit video;
		int exp_len;
		if (exp_video.size() == 0) begin
			stop_with_message("frame sent while none was expected");
		end
		video   = exp_video.pop_front();
		exp_len = video ? VIDEO_LEN : AUDIO_LEN;
		assert (cap_frame.size() == exp_len)
		else flag_mismatch("frame length", longint'(exp_len), longint'(cap_frame.size()));
		// Arbitration order shows in the type byte
		assert (cap_frame[TYPE_POS] == (video ? gmii_pkg::PKT_VIDEO : gmii_pkg::PKT_AUDIO))
		else flag_mismatch("packet type", longint'(!video), longint'(cap_frame[TYPE_POS]));
		if (video && pix_queue.size() < VIDEO_PIXELS) begin
			stop_with_message("video frame without a full line queued");
		end
		if (!video && aud_queue.size() < AUX_SAMPLES) begin
			stop_with_message("audio frame without a full block queued");
		end
		build_expected(video, frame_sid, exp_line);
		if (video) begin
			exp_line = (exp_line == VIDEO_LINES - 1) ? 0 : exp_line + 1;
		end
		for (int i = 0; i < exp_len - 4; i++) begin
			assert (cap_frame[i] == exp_frame[i])
			else flag_mismatch($sformatf("frame %0d byte %0d", frames_done, i),
				longint'(exp_frame[i]), longint'(cap_frame[i]));
		end
		for (int i = exp_len - 4; i < exp_len; i++) begin
			assert (cap_frame[i] == exp_frame[i])
			else flag_mismatch($sformatf("frame %0d FCS byte %0d", frames_done, i - exp_len + 4),
				longint'(exp_frame[i]), longint'(cap_frame[i]));
		end
		frames_done++;
	endtask

	always @(negedge fifo_clk) begin
		if (tx_en) begin
			if (cap_frame.size() == 0) begin
				frame_sid = station_id;
				assert (idle_cycles >= gmii_pkg::GAP_CYCLES)
				else flag_mismatch("idle cycles before frame",
					longint'(gmii_pkg::GAP_CYCLES), longint'(idle_cycles));
			end
			cap_frame.push_back(txd);
		end else begin
			if (cap_frame.size() != 0) begin
				check_frame();
				cap_frame   = {};
				idle_cycles = 0;
			end
			idle_cycles++;
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	task automatic apply_reset();
		@(negedge fifo_clk);
		sys_rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge fifo_clk);
		sys_rst  = 1'b0;
		exp_line = 0;
	endtask

	// Words past keep land in a full buffer and are lost
	task automatic write_pixels(input int count, input int keep);
		gmii_pkg::pixel_t w;
		for (int i = 0; i < count; i++) begin
			w = lcg_next();
			@(negedge fifo_clk);
			pix_wr   = 1'b1;
			pix_data = w;
			if (i < keep) begin
				pix_queue.push_back(w);
			end
		end
		@(negedge fifo_clk);
		pix_wr = 1'b0;
	endtask

	task automatic write_samples(input int count, input int keep);
		gmii_pkg::sample_t s;
		for (int i = 0; i < count; i++) begin
			s = lcg_next();
			@(negedge fifo_clk);
			aud_wr   = 1'b1;
			aud_data = s;
			if (i < keep) begin
				aud_queue.push_back(s);
			end
		end
		@(negedge fifo_clk);
		aud_wr = 1'b0;
	endtask

	task automatic expect_frame(input bit video);
		exp_video.push_back(video);
		frames_planned++;
	endtask

	task automatic wait_all_frames();
		while (frames_done < frames_planned) begin
			@(negedge fifo_clk);
		end
		@(negedge fifo_clk);
	endtask

	initial begin
		sys_rst    = 1'b1;
		station_id = 1'b0;
		pix_wr     = 1'b0;
		pix_data   = '0;
		aud_wr     = 1'b0;
		aud_data   = '0;
		lcg_state  = 32'hca65;
		test_name  = "reset";
		apply_reset();

		// One frame of each kind
		test_name = "station0";
		expect_frame(1'b1);
		write_pixels(VIDEO_PIXELS, VIDEO_PIXELS);
		wait_all_frames();
		expect_frame(1'b0);
		write_samples(AUX_SAMPLES, AUX_SAMPLES);
		wait_all_frames();

		// Line and block both waiting when the first frame ends
		test_name = "arbitration";
		expect_frame(1'b1);
		expect_frame(1'b0);
		expect_frame(1'b1);
		write_pixels(VIDEO_PIXELS, VIDEO_PIXELS);
		wait (tx_en);
		write_pixels(VIDEO_PIXELS, VIDEO_PIXELS);
		write_samples(AUX_SAMPLES, AUX_SAMPLES);
		wait_all_frames();

		test_name = "station1";
		station_id = 1'b1;
		expect_frame(1'b1);
		write_pixels(VIDEO_PIXELS, VIDEO_PIXELS);
		wait_all_frames();
		expect_frame(1'b0);
		write_samples(AUX_SAMPLES, AUX_SAMPLES);
		wait_all_frames();

		// First frame starts before reads, so 16 fit and the rest drop
		test_name = "video_overflow";
		expect_frame(1'b1);
		expect_frame(1'b1);
		write_pixels(FIFO_DEPTH + 4, FIFO_DEPTH);
		assert (vid_overflow)
		else flag_mismatch("vid_overflow", 64'd1, longint'(vid_overflow));
		wait_all_frames();

		test_name = "audio_overflow";
		repeat (FIFO_DEPTH / AUX_SAMPLES) expect_frame(1'b0);
		write_samples(FIFO_DEPTH + 4, FIFO_DEPTH);
		assert (aud_overflow && vid_overflow)
		else flag_mismatch("aud_overflow and vid_overflow", 64'd3,
			longint'({aud_overflow, vid_overflow}));
		wait_all_frames();

		// Fresh reset clears flags and restarts line numbering
		test_name = "second_reset";
		apply_reset();
		assert (!vid_overflow && !aud_overflow)
		else flag_mismatch("overflow flags", 64'd0, longint'({aud_overflow, vid_overflow}));
		expect_frame(1'b1);
		write_pixels(VIDEO_PIXELS, VIDEO_PIXELS);
		wait_all_frames();

		test_name = "end";
		if (frames_done == frames_planned && pix_queue.size() == 0 && aud_queue.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("frames or queued words left over at the end of the run");
			$display("Checks failed");
			$fatal(1);
		end
	end

	// Watchdog, generous bound over 20 of the longest frames
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired in %s with %0d of %0d frames seen",
			test_name, frames_done, frames_planned);
		$display("Checks failed");
		$fatal(1);
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
src/gmii_pkg.sv
src/crc32_gen.sv
src/video_line_buffer.sv
src/aux_sample_buffer.sv
src/frame_arbiter.sv
src/gmii_frame_tx.sv
src/gmii_udp_top.sv
testbench/tb_gmii_udp.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GMII UDP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_gmii_udp -o sim_tb_gmii_udp
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tb_gmii_udp
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
